// File: Makefile
# Verilator build and run for the game console memory bus

VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_gb_memory_bus
FILE_LIST  = gb_memory_bus.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: gb_memory_bus.f
+incdir+verilog
verilog/gb_bus_pkg.sv
verilog/bus_if.sv
verilog/address_decoder.sv
verilog/boot_interrupt_regs.sv
verilog/work_ram.sv
verilog/read_mux.sv
verilog/gb_memory_bus.sv
test/tb_gb_memory_bus.sv

// File: test/tb_gb_memory_bus.sv
// ----------------------------------------------------------
// Testbench for the game console memory bus
// Reset, boot split, work RAM, IF, unmapped space, bootstrap
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "gb_bus_defines.svh"

module tb_gb_memory_bus;

   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 8;
   localparam int WAIT_LIMIT   = 100;
   localparam int RUN_LIMIT    = 20000;

   logic                    clock;
   logic                    reset;
   gb_bus_pkg::addr_t       addr;
   gb_bus_pkg::byte_t       wdata;
   logic                    mem_we;
   logic                    mem_re;
   logic                    irq_vblank;
   logic                    irq_lcdc;
   logic                    irq_timer;
   logic                    irq_joypad;
   logic [15:0]             flash_d;
   gb_bus_pkg::byte_t       rdata;
   gb_bus_pkg::irq_flags_t  if_flags;
   gb_bus_pkg::flash_addr_t flash_a;
   logic                    flash_adv_n;

   int                checks;
   int                errors;
   int                tests_run;
   int                tests_failed;
   int                errors_at_start;
   string             test_name;
   gb_bus_pkg::byte_t ram_model [gb_bus_pkg::addr_t];

   gb_memory_bus i_gb_memory_bus (.*);

   // Flash model returns a[7:0] ^ a[15:8] in the low byte
   assign flash_d = {flash_a[15:8], flash_a[7:0] ^ flash_a[15:8]};

   initial begin
      clock = 1'b0;
      forever #HALF_PERIOD clock = ~clock;
   end

   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
   end

   initial begin
      repeat (RUN_LIMIT) @(posedge clock);
      $display("Run did not finish within %0d cycles", RUN_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
   end

   adv_follows_re: assert property (@(posedge clock) disable iff (reset)
                                    flash_adv_n == !mem_re)
      else begin
         errors++;
         $display("error %s (flash_adv_n): expected %0h actual %0h", test_name,
                  !$sampled(mem_re), $sampled(flash_adv_n));
      end

   function automatic gb_bus_pkg::flash_addr_t cart_flash_addr(input gb_bus_pkg::addr_t a,
                                                               input logic boot_on);
      return (boot_on && a <= `BOOT_IMAGE_END) ? {8'h00, a} :
             {8'h00, a} + 24'(`CART_FLASH_OFFSET);
   endfunction

   function automatic gb_bus_pkg::byte_t flash_byte(input gb_bus_pkg::flash_addr_t fa);
      return fa[7:0] ^ fa[15:8];
   endfunction

   function automatic logic is_kept(input gb_bus_pkg::addr_t a);
      return (a <= `MEM_CART_END) || (a >= `MEM_WRAM_START && a <= `MEM_ECHO_END) ||
             (a == `MMIO_IF) || (a == `MMIO_BOOTSTRAP);
   endfunction

   task automatic check_value(input string what, input logic [23:0] expected,
                              input logic [23:0] actual);
      checks++;
      value_ok: assert (actual === expected)
         else begin
            errors++;
            $display("error %s (%s): expected %0h actual %0h", test_name, what, expected,
                     actual);
         end
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test;
      tests_run++;
      if (errors > errors_at_start) begin
         tests_failed++;
         $display("test %s failed", test_name);
      end else begin
         $display("test %s passed", test_name);
      end
   endtask

   // One bus cycle driven on the falling edge
   task automatic drive_cycle(input gb_bus_pkg::addr_t a, input gb_bus_pkg::byte_t d,
                              input logic we, input logic re,
                              input gb_bus_pkg::irq_flags_t irq);
      @(negedge clock);
      addr       = a;
      wdata      = d;
      mem_we     = we;
      mem_re     = re;
      irq_vblank = irq[`IRQ_VBLANK];
      irq_lcdc   = irq[`IRQ_LCDC];
      irq_timer  = irq[`IRQ_TIMER];
      irq_joypad = irq[`IRQ_JOYPAD];
   endtask

   task automatic idle_cycle;
      drive_cycle(addr, wdata, 1'b0, 1'b0, '0);
   endtask

   task automatic bus_write(input gb_bus_pkg::addr_t a, input gb_bus_pkg::byte_t d,
                            input gb_bus_pkg::irq_flags_t irq);
      drive_cycle(a, d, 1'b1, 1'b0, irq);
      idle_cycle();
   endtask

   task automatic pulse_requests(input gb_bus_pkg::irq_flags_t irq);
      drive_cycle(addr, wdata, 1'b0, 1'b0, irq);
      idle_cycle();
   endtask

   // Read sampled at edge N shows its byte on rdata after edge N+1
   task automatic bus_read(input gb_bus_pkg::addr_t a, output gb_bus_pkg::byte_t data,
                           output gb_bus_pkg::flash_addr_t fa);
      drive_cycle(a, 8'h00, 1'b0, 1'b1, '0);
      #1;
      fa = flash_a;
      idle_cycle();
      idle_cycle();
      data = rdata;
   endtask

   task automatic run_tests;
      gb_bus_pkg::byte_t       data;
      gb_bus_pkg::byte_t       d;
      gb_bus_pkg::flash_addr_t fa;
      gb_bus_pkg::addr_t       a;
      gb_bus_pkg::addr_t       cart_addrs [$];

      start_test("reset");
      check_value("rdata", 24'h0, 24'(rdata));
      check_value("if_flags", 24'h0, 24'(if_flags));
      check_value("flash_adv_n", 24'h1, 24'(flash_adv_n));
      bus_read(`MMIO_BOOTSTRAP, data, fa);
      check_value("boot byte", 24'h0, 24'(data));
      end_test();

      // Boot mode is still on here
      start_test("boot_split");
      cart_addrs = {16'h0000, `BOOT_IMAGE_END, `CART_FLASH_OFFSET, `MEM_CART_END};
      repeat (4) cart_addrs.push_back(16'($urandom_range(32'h0103)));
      repeat (8) cart_addrs.push_back(16'($urandom_range(32'h7FFF)));
      foreach (cart_addrs[i]) begin
         bus_read(cart_addrs[i], data, fa);
         check_value("flash_a", cart_flash_addr(cart_addrs[i], 1'b1), fa);
         check_value("rdata", 24'(flash_byte(cart_flash_addr(cart_addrs[i], 1'b1))),
                     24'(data));
      end
      end_test();

      // Indices kept below the echo limit so every byte has a mirror
      start_test("work_ram");
      for (int i = 0; i < 16; i++) begin
         a = `MEM_WRAM_START + 16'($urandom_range(32'h1DFF));
         d = 8'($urandom);
         ram_model[a] = d;
         drive_cycle(a, d, 1'b1, 1'b0, '0);
         bus_read(a, data, fa);
         check_value("direct", 24'(d), 24'(data));
      end
      foreach (ram_model[k]) begin
         bus_read(k + 16'h2000, data, fa);
         check_value("echo", 24'(ram_model[k]), 24'(data));
      end
      end_test();

      start_test("interrupt_flags");
      bus_write(`MMIO_IF, 8'h00, '0);
      check_value("cleared", 24'h00, 24'(if_flags));
      pulse_requests(5'b00101);
      check_value("vblank timer", 24'h05, 24'(if_flags));
      bus_read(`MMIO_IF, data, fa);
      check_value("read IF", 24'h05, 24'(data));
      pulse_requests(5'b10010);
      check_value("lcdc joypad", 24'h17, 24'(if_flags));
      bus_read(`MMIO_IF, data, fa);
      check_value("read IF", 24'h17, 24'(data));
      bus_write(`MMIO_IF, 8'hEA, '0);
      check_value("write replaces", 24'h0A, 24'(if_flags));
      bus_write(`MMIO_IF, 8'h04, 5'b11111);
      check_value("write wins", 24'h04, 24'(if_flags));
      bus_write(`MMIO_IF, 8'h00, '0);
      pulse_requests(5'b11111);
      check_value("no serial request", 24'h17, 24'(if_flags));
      end_test();

      // IF holds 0x17 from the last test and boot mode is still on
      start_test("unmapped");
      for (int i = 0; i < 16; i++) begin
         a = 16'($urandom);
         while (is_kept(a)) begin
            a = 16'($urandom);
         end
         bus_write(a, 8'($urandom), '0);
         bus_read(a, data, fa);
         check_value("reads zero", 24'h00, 24'(data));
      end
      check_value("IF kept", 24'h17, 24'(if_flags));
      bus_read(`MMIO_BOOTSTRAP, data, fa);
      check_value("boot byte kept", 24'h00, 24'(data));
      foreach (ram_model[k]) begin
         bus_read(k, data, fa);
         check_value("ram kept", 24'(ram_model[k]), 24'(data));
      end
      end_test();

      // Ends boot mode and therefore runs last
      start_test("bootstrap");
      bus_read(16'h0050, data, fa);
      check_value("boot image", 24'h000050, fa);
      bus_write(`MMIO_BOOTSTRAP, 8'h01, '0);
      bus_read(`MMIO_BOOTSTRAP, data, fa);
      check_value("readback", 24'h01, 24'(data));
      bus_read(16'h0050, data, fa);
      check_value("flash_a", 24'h000154, fa);
      check_value("rdata", 24'(flash_byte(24'h000154)), 24'(data));
      end_test();
   endtask

   initial begin
      int wait_count;

      void'($urandom(32'h9482));
      addr       = '0;
      wdata      = '0;
      mem_we     = 1'b0;
      mem_re     = 1'b0;
      irq_vblank = 1'b0;
      irq_lcdc   = 1'b0;
      irq_timer  = 1'b0;
      irq_joypad = 1'b0;
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;

      wait_count = 0;
      while (reset !== 1'b0 && wait_count < WAIT_LIMIT) begin
         @(negedge clock);
         wait_count++;
      end
      if (reset !== 1'b0) begin
         errors++;
         $display("Reset was not released within %0d cycles", WAIT_LIMIT);
      end else begin
         run_tests();
      end

      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
               checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/address_decoder.sv
// ----------------------------------------------------------
// Address decoder
// Splits the CPU address into regions, raises write enables,
// folds the echo range onto work RAM and forms the flash
// address for cartridge and boot image reads
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "gb_bus_defines.svh"

module address_decoder (
   bus_if.decode                    bus,
   input  logic                     boot_done,
   output logic                     wram_we,
   output gb_bus_pkg::wram_index_t  wram_index,
   output logic                     if_write,
   output logic                     boot_write,
   output gb_bus_pkg::read_src_t    read_src,
   output gb_bus_pkg::flash_addr_t  flash_a
);

   logic              in_cart;
   logic              in_boot_image;
   logic              in_wram;
   logic              in_echo;
   logic              in_if;
   logic              in_boot_reg;
   gb_bus_pkg::addr_t wram_base;

   // Cartridge window starts at address zero
   assign in_cart       = bus.addr <= `MEM_CART_END;
   assign in_boot_image = !boot_done && (bus.addr <= `BOOT_IMAGE_END);

   assign in_wram = (bus.addr >= `MEM_WRAM_START) && (bus.addr <= `MEM_WRAM_END);
   assign in_echo = (bus.addr >= `MEM_ECHO_START) && (bus.addr <= `MEM_ECHO_END);

   assign in_if       = bus.addr == `MMIO_IF;
   assign in_boot_reg = bus.addr == `MMIO_BOOTSTRAP;

   // Echo is a second view of the same 8 KB
   assign wram_base  = in_echo ? `MEM_ECHO_START : `MEM_WRAM_START;
   assign wram_index = gb_bus_pkg::wram_index_t'(bus.addr - wram_base);

   assign wram_we    = (in_wram || in_echo) && bus.we;
   assign if_write   = in_if && bus.we;
   assign boot_write = in_boot_reg && bus.we;

   // Boot image is read in place
   // Cartridge data sits behind it in flash
   assign flash_a = (in_cart && !in_boot_image) ?
                    gb_bus_pkg::flash_addr_t'(bus.addr) +
                    gb_bus_pkg::flash_addr_t'(`CART_FLASH_OFFSET) :
                    gb_bus_pkg::flash_addr_t'(bus.addr);

   always_comb begin
      if (!bus.re) begin
         read_src = `SRC_ZERO;
      end else if (in_cart) begin
         read_src = `SRC_FLASH;
      end else if (in_wram || in_echo) begin
         read_src = `SRC_WRAM;
      end else if (in_if) begin
         read_src = `SRC_IF;
      end else if (in_boot_reg) begin
         read_src = `SRC_BOOT;
      end else begin
         // Unmapped space reads as zero
         read_src = `SRC_ZERO;
      end
   end

endmodule

`default_nettype wire

// File: verilog/boot_interrupt_regs.sv
// ----------------------------------------------------------
// Bootstrap and interrupt flag registers
// Bootstrap bit 0 ends boot mode, IF merges hardware
// requests with CPU writes
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "gb_bus_defines.svh"

module boot_interrupt_regs (
   input  logic                   clock,
   input  logic                   reset,
   bus_if.regs                    bus,
   input  logic                   if_write,
   input  logic                   boot_write,
   input  logic                   irq_vblank,
   input  logic                   irq_lcdc,
   input  logic                   irq_timer,
   input  logic                   irq_joypad,
   output gb_bus_pkg::irq_flags_t if_flags,
   output gb_bus_pkg::byte_t      boot_data,
   output logic                   boot_done
);

   gb_bus_pkg::irq_flags_t irq_req;

   // Request pulses placed at their flag positions
   always_comb begin
      irq_req[`IRQ_VBLANK] = irq_vblank;
      irq_req[`IRQ_LCDC]   = irq_lcdc;
      irq_req[`IRQ_TIMER]  = irq_timer;
      // No serial port, flag moves only on a write
      irq_req[`IRQ_SERIAL] = 1'b0;
      irq_req[`IRQ_JOYPAD] = irq_joypad;
   end

   // CPU write wins over a request in the same cycle
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_flags <= '0;
      end else if (if_write) begin
         if_flags <= bus.wdata[4:0];
      end else begin
         if_flags <= if_flags | irq_req;
      end
   end

   // Zero after reset, so the boot image is mapped
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         boot_data <= '0;
      end else if (boot_write) begin
         boot_data <= bus.wdata;
      end
   end

   assign boot_done = boot_data[0];

endmodule

`default_nettype wire

// File: verilog/bus_if.sv
// ----------------------------------------------------------
// CPU access bundle
// Address, write data and the read and write strobes
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface bus_if;
   gb_bus_pkg::addr_t addr;
   gb_bus_pkg::byte_t wdata;
   logic              we;
   logic              re;

   modport source (output addr, wdata, we, re);
   modport decode (input addr, we, re);
   modport regs   (input wdata);
   modport ram    (input wdata);
endinterface

`default_nettype wire

// File: verilog/gb_bus_defines.svh
// ----------------------------------------------------------
// Game console bus definitions
// Memory map, register addresses, read source codes and
// interrupt flag bit positions
// ----------------------------------------------------------
`ifndef GB_BUS_DEFINES_SVH
`define GB_BUS_DEFINES_SVH

// Cartridge window, served from external flash
`define MEM_CART_START    16'h0000
`define MEM_CART_END      16'h7FFF
`define BOOT_IMAGE_END    16'h0103
`define CART_FLASH_OFFSET 16'h0104

// Work RAM and its mirror
`define MEM_WRAM_START    16'hC000
`define MEM_WRAM_END      16'hDFFF
`define MEM_ECHO_START    16'hE000
`define MEM_ECHO_END      16'hFDFF

// Memory mapped registers
`define MMIO_IF           16'hFF0F
`define MMIO_BOOTSTRAP    16'hFF50

// Read source select
`define SRC_ZERO          3'd0
`define SRC_FLASH         3'd1
`define SRC_WRAM          3'd2
`define SRC_IF            3'd3
`define SRC_BOOT          3'd4

// Bit positions in IF
`define IRQ_VBLANK        0
`define IRQ_LCDC          1
`define IRQ_TIMER         2
`define IRQ_SERIAL        3
`define IRQ_JOYPAD        4

`endif

// File: verilog/gb_bus_pkg.sv
// ----------------------------------------------------------
// Game console bus types
// Vector types shared by the bus decode, registers and RAM
// ----------------------------------------------------------
`default_nettype none

package gb_bus_pkg;

   // CPU side
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // External flash word address
   typedef logic [23:0] flash_addr_t;

   // 8 KB work RAM
   typedef logic [12:0] wram_index_t;

   // vblank, lcdc, timer, serial, joypad
   typedef logic [4:0]  irq_flags_t;

   // Which block answers a read
   typedef logic [2:0]  read_src_t;

endpackage

`default_nettype wire

// File: verilog/gb_memory_bus.sv
// ----------------------------------------------------------
// Game console memory bus
// Address decode, work RAM, boot and interrupt registers and
// the read path between the CPU and external flash
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module gb_memory_bus (
   input  logic                    clock,
   input  logic                    reset,
   input  gb_bus_pkg::addr_t       addr,
   input  gb_bus_pkg::byte_t       wdata,
   input  logic                    mem_we,
   input  logic                    mem_re,
   input  logic                    irq_vblank,
   input  logic                    irq_lcdc,
   input  logic                    irq_timer,
   input  logic                    irq_joypad,
   input  logic [15:0]             flash_d,
   output gb_bus_pkg::byte_t       rdata,
   output gb_bus_pkg::irq_flags_t  if_flags,
   output gb_bus_pkg::flash_addr_t flash_a,
   output logic                    flash_adv_n
);

   logic                    wram_we;
   gb_bus_pkg::wram_index_t wram_index;
   gb_bus_pkg::byte_t       wram_data;
   logic                    if_write;
   logic                    boot_write;
   logic                    boot_done;
   gb_bus_pkg::byte_t       boot_data;
   gb_bus_pkg::read_src_t   read_src;

   bus_if bus ();

   assign bus.addr  = addr;
   assign bus.wdata = wdata;
   assign bus.we    = mem_we;
   assign bus.re    = mem_re;

   // Flash address is valid while the read strobe is high
   assign flash_adv_n = ~mem_re;

   address_decoder i_address_decoder (
      .bus        (bus),
      .boot_done  (boot_done),
      .wram_we    (wram_we),
      .wram_index (wram_index),
      .if_write   (if_write),
      .boot_write (boot_write),
      .read_src   (read_src),
      .flash_a    (flash_a)
   );

   boot_interrupt_regs i_boot_interrupt_regs (
      .clock      (clock),
      .reset      (reset),
      .bus        (bus),
      .if_write   (if_write),
      .boot_write (boot_write),
      .irq_vblank (irq_vblank),
      .irq_lcdc   (irq_lcdc),
      .irq_timer  (irq_timer),
      .irq_joypad (irq_joypad),
      .if_flags   (if_flags),
      .boot_data  (boot_data),
      .boot_done  (boot_done)
   );

   work_ram i_work_ram (
      .clock      (clock),
      .bus        (bus),
      .wram_we    (wram_we),
      .wram_index (wram_index),
      .rdata      (wram_data)
   );

   read_mux i_read_mux (
      .clock      (clock),
      .reset      (reset),
      .re         (mem_re),
      .read_src   (read_src),
      .wram_data  (wram_data),
      .flash_d    (flash_d),
      .if_flags   (if_flags),
      .boot_data  (boot_data),
      .rdata      (rdata)
   );

endmodule

`default_nettype wire

// File: verilog/read_mux.sv
// ----------------------------------------------------------
// Read data multiplexer
// Samples the addressed source on a read strobe and drives
// the result on rdata one cycle later, held until the next
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "gb_bus_defines.svh"

module read_mux (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   re,
   input  gb_bus_pkg::read_src_t  read_src,
   input  gb_bus_pkg::byte_t      wram_data,
   input  logic [15:0]            flash_d,
   input  gb_bus_pkg::irq_flags_t if_flags,
   input  gb_bus_pkg::byte_t      boot_data,
   output gb_bus_pkg::byte_t      rdata
);

   gb_bus_pkg::read_src_t src_q;
   gb_bus_pkg::byte_t     hold_q;
   gb_bus_pkg::byte_t     sampled;
   logic                  pending_q;

   // Work RAM is not here, its byte arrives a cycle later
   always_comb begin
      case (read_src)
         `SRC_FLASH: sampled = flash_d[7:0];
         `SRC_IF:    sampled = {3'b000, if_flags};
         `SRC_BOOT:  sampled = boot_data;
         default:    sampled = '0;
      endcase
   end

   always_ff @(posedge clock) begin
      if (re) begin
         hold_q <= sampled;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         pending_q <= 1'b0;
         src_q     <= `SRC_ZERO;
         rdata     <= '0;
      end else begin
         pending_q <= re;
         if (re) begin
            src_q <= read_src;
         end
         if (pending_q) begin
            rdata <= (src_q == `SRC_WRAM) ? wram_data : hold_q;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/work_ram.sv
// ----------------------------------------------------------
// Work RAM
// 8192 bytes, one write port and a registered read
// ----------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module work_ram (
   input  logic                    clock,
   bus_if.ram                      bus,
   input  logic                    wram_we,
   input  gb_bus_pkg::wram_index_t wram_index,
   output gb_bus_pkg::byte_t       rdata
);

   gb_bus_pkg::byte_t mem [0:8191];

   always_ff @(posedge clock) begin
      if (wram_we) begin
         mem[wram_index] <= bus.wdata;
      end
   end

   // Read every cycle
   // A write to the same index shows up one cycle later
   always_ff @(posedge clock) begin
      rdata <= mem[wram_index];
   end

endmodule

`default_nettype wire
